/* dtlb.sv */
// Fully associative data TLB

`timescale 1ns/1ps

`include "mmu_params.svh"

module dtlb #(
    parameter int unsigned TLB_ENTRIES = `MMU_TLB_ENTRIES
) (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           flush_i,
    // refill
    input  logic           upd_valid_i,
    input  mmu_pkg::vpn_t  upd_vpn_i,
    input  mmu_pkg::ppn_t  upd_ppn_i,
    input  logic           upd_is_2m_i,
    input  logic           upd_is_1g_i,
    input  mmu_pkg::perm_t upd_perm_i,
    // lookup
    input  logic           lu_access_i,
    input  mmu_pkg::vaddr_t lu_vaddr_i,
    output logic           lu_hit_o,
    output mmu_pkg::ppn_t  lu_ppn_o,
    output mmu_pkg::perm_t lu_perm_o,
    output logic           lu_is_2m_o,
    output logic           lu_is_1g_o
);

    localparam int unsigned PTR_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    // entry storage
    logic [TLB_ENTRIES-1:0] valid_q;
    mmu_pkg::vpn_t          tag_q   [TLB_ENTRIES];
    mmu_pkg::ppn_t          ppn_q   [TLB_ENTRIES];
    mmu_pkg::perm_t         perm_q  [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] is_2m_q;
    logic [TLB_ENTRIES-1:0] is_1g_q;

    // next entry to overwrite
    logic [PTR_W-1:0] repl_ptr_q;

    mmu_pkg::vpn_t          lu_vpn;
    logic [TLB_ENTRIES-1:0] entry_match;

    assign lu_vpn = lu_vaddr_i[`MMU_VLEN-1:12];

    // ----------------------------------------
    // tag match
    // ----------------------------------------

    // large pages ignore the lower levels of the vpn
    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_match
        logic lvl2_eq;
        logic lvl1_eq;
        logic lvl0_eq;

        assign lvl2_eq = (tag_q[i][26:18] == lu_vpn[26:18]);
        assign lvl1_eq = (tag_q[i][17:9] == lu_vpn[17:9]);
        assign lvl0_eq = (tag_q[i][8:0] == lu_vpn[8:0]);

        assign entry_match[i] = valid_q[i] & lvl2_eq
                              & (is_1g_q[i] | (lvl1_eq & (is_2m_q[i] | lvl0_eq)));
    end

    // walk down so the lowest matching index is taken last
    always_comb begin : hit_select
        lu_ppn_o   = '0;
        lu_perm_o  = '0;
        lu_is_2m_o = 1'b0;
        lu_is_1g_o = 1'b0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entry_match[i]) begin
                lu_ppn_o   = ppn_q[i];
                lu_perm_o  = perm_q[i];
                lu_is_2m_o = is_2m_q[i];
                lu_is_1g_o = is_1g_q[i];
            end
        end
    end

    assign lu_hit_o = lu_access_i & (|entry_match);

    // ----------------------------------------
    // refill and flush
    // ----------------------------------------

    // flush beats an update in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            repl_ptr_q <= '0;
        end else begin
            if (flush_i) begin
                valid_q <= '0;
            end else if (upd_valid_i) begin
                valid_q[repl_ptr_q] <= 1'b1;
            end

            // round robin, untouched by flush
            if (upd_valid_i) begin
                if (repl_ptr_q == PTR_W'(TLB_ENTRIES - 1)) begin
                    repl_ptr_q <= '0;
                end else begin
                    repl_ptr_q <= repl_ptr_q + 1'b1;
                end
            end
        end
    end

    // entry payload, only meaningful while the valid bit is set
    always_ff @(posedge clk_i) begin
        if (upd_valid_i) begin
            tag_q[repl_ptr_q]   <= upd_vpn_i;
            ppn_q[repl_ptr_q]   <= upd_ppn_i;
            perm_q[repl_ptr_q]  <= upd_perm_i;
            is_2m_q[repl_ptr_q] <= upd_is_2m_i;
            is_1g_q[repl_ptr_q] <= upd_is_1g_i;
        end
    end

endmodule

/* filelist.f */
+incdir+.
mmu_pkg.sv
dtlb.sv
lsu_xlate.sv
mmu_top.sv
mmu_tb.sv

/* lsu_xlate.sv */
// Load/store address translation stage

`timescale 1ns/1ps

`include "mmu_params.svh"

module lsu_xlate (
    input  logic            clk_i,
    input  logic            rst_ni,
    // control levels
    input  logic            en_translation_i,
    input  mmu_pkg::priv_t  priv_lvl_i,
    input  logic            sum_i,
    // request from the load/store unit
    input  logic            lsu_req_i,
    input  mmu_pkg::vaddr_t lsu_vaddr_i,
    input  logic            lsu_is_store_i,
    // same-cycle lookup result
    input  logic            lu_hit_i,
    input  mmu_pkg::ppn_t   lu_ppn_i,
    input  mmu_pkg::perm_t  lu_perm_i,
    input  logic            lu_is_2m_i,
    input  logic            lu_is_1g_i,
    // response, one cycle after the request
    output logic            lsu_valid_o,
    output mmu_pkg::paddr_t lsu_paddr_o,
    output logic            lsu_ex_valid_o,
    output mmu_pkg::cause_t lsu_ex_cause_o,
    output mmu_pkg::tval_t  lsu_ex_tval_o
);

    // registered request and lookup
    logic            req_q;
    logic            hit_q;
    logic            en_q;
    mmu_pkg::priv_t  priv_q;
    logic            sum_q;
    logic            is_store_q;
    mmu_pkg::vaddr_t vaddr_q;
    mmu_pkg::ppn_t   ppn_q;
    mmu_pkg::perm_t  perm_q;
    logic            is_2m_q;
    logic            is_1g_q;

    mmu_pkg::paddr_t paddr_xlate;
    logic            priv_err;
    logic            ld_fault;
    logic            st_fault;
    logic            fault;

    // ----------------------------------------
    // pipeline register
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
            en_q  <= 1'b0;
        end else begin
            req_q <= lsu_req_i;
            hit_q <= lu_hit_i;
            en_q  <= en_translation_i;
        end
    end

    // the privilege context travels with the request
    always_ff @(posedge clk_i) begin
        priv_q     <= priv_lvl_i;
        sum_q      <= sum_i;
        is_store_q <= lsu_is_store_i;
        vaddr_q    <= lsu_vaddr_i;
        ppn_q      <= lu_ppn_i;
        perm_q     <= lu_perm_i;
        is_2m_q    <= lu_is_2m_i;
        is_1g_q    <= lu_is_1g_i;
    end

    // ----------------------------------------
    // physical address
    // ----------------------------------------

    // large pages take the low vpn levels from the virtual address
    always_comb begin : paddr_build
        paddr_xlate = {ppn_q, vaddr_q[11:0]};
        if (is_2m_q) begin
            paddr_xlate[20:12] = vaddr_q[20:12];
        end
        if (is_1g_q) begin
            paddr_xlate[29:12] = vaddr_q[29:12];
        end
    end

    // bypass zero-extends the virtual address
    assign lsu_paddr_o = en_q ? paddr_xlate
                              : {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, vaddr_q};

    // ----------------------------------------
    // permission checks
    // ----------------------------------------

    // user pages need SUM in supervisor mode, user mode needs the u bit
    assign priv_err = ((priv_q == mmu_pkg::priv_t'(`MMU_PRIV_S)) && !sum_q
                       && perm_q[`MMU_PERM_U])
                    || ((priv_q == mmu_pkg::priv_t'(`MMU_PRIV_U))
                       && !perm_q[`MMU_PERM_U]);

    assign ld_fault = priv_err || !perm_q[`MMU_PERM_R];

    // stores also need the dirty bit, there is no hardware update of it
    assign st_fault = priv_err || !perm_q[`MMU_PERM_W] || !perm_q[`MMU_PERM_D];

    assign fault = is_store_q ? st_fault : ld_fault;

    // ----------------------------------------
    // response
    // ----------------------------------------

    // a translated miss stays silent, the requester retries later
    assign lsu_valid_o = req_q && (!en_q || hit_q);

    assign lsu_ex_valid_o = req_q && en_q && hit_q && fault;

    always_comb begin : ex_build
        lsu_ex_cause_o = '0;
        lsu_ex_tval_o  = '0;
        if (lsu_ex_valid_o) begin
            if (is_store_q) begin
                lsu_ex_cause_o = mmu_pkg::cause_t'(`MMU_CAUSE_ST_PF);
            end else begin
                lsu_ex_cause_o = mmu_pkg::cause_t'(`MMU_CAUSE_LD_PF);
            end
            // tval is the sign-extended virtual address
            lsu_ex_tval_o = {{(`MMU_XLEN - `MMU_VLEN){vaddr_q[`MMU_VLEN-1]}}, vaddr_q};
        end
    end

endmodule

/* mmu_params.svh */
// Sv39 data MMU parameters

`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// address and page number widths
`define MMU_VLEN 39
`define MMU_PLEN 56
`define MMU_PPNW 44
`define MMU_VPNW 27
`define MMU_XLEN 64

// data TLB size
`define MMU_TLB_ENTRIES 4

// page fault cause codes
`define MMU_CAUSE_LD_PF 13
`define MMU_CAUSE_ST_PF 15

// bit positions inside a permission word
`define MMU_PERM_R 0
`define MMU_PERM_W 1
`define MMU_PERM_U 2
`define MMU_PERM_D 3

// privilege level codes
`define MMU_PRIV_U 0
`define MMU_PRIV_S 1

`endif

/* mmu_pkg.sv */
// Sv39 data MMU types

`include "mmu_params.svh"

package mmu_pkg;

    // ----------------------------------------
    // addresses and page numbers
    // ----------------------------------------

    // virtual address, bits 38:0
    typedef logic [`MMU_VLEN-1:0] vaddr_t;

    // physical address, bits 55:0
    typedef logic [`MMU_PLEN-1:0] paddr_t;

    // physical page number
    typedef logic [`MMU_PPNW-1:0] ppn_t;

    // virtual page number, three 9-bit levels
    // level 2 in 26:18, level 1 in 17:9, level 0 in 8:0
    typedef logic [`MMU_VPNW-1:0] vpn_t;

    // ----------------------------------------
    // permissions and exceptions
    // ----------------------------------------

    // pte bits r, w, u, d
    typedef logic [3:0] perm_t;

    // privilege level
    typedef logic [1:0] priv_t;

    // exception cause and value
    typedef logic [5:0] cause_t;
    typedef logic [`MMU_XLEN-1:0] tval_t;

endpackage

/* mmu_tb.sv */
// Sv39 data MMU testbench

`timescale 1ns/1ps

`include "mmu_params.svh"

module mmu_tb;

    localparam int    CLK_PERIOD = 40;
    localparam int    SEED       = 83;
    localparam string VEC_FILE   = "mmu_vectors.txt";

    // DUT ports named as on mmu_top
    logic            clk_i;
    logic            rst_ni;
    logic            flush_i;
    logic            en_translation_i;
    mmu_pkg::priv_t  priv_lvl_i;
    logic            sum_i;
    logic            lsu_req_i;
    mmu_pkg::vaddr_t lsu_vaddr_i;
    logic            lsu_is_store_i;
    logic            upd_valid_i;
    mmu_pkg::vpn_t   upd_vpn_i;
    mmu_pkg::ppn_t   upd_ppn_i;
    logic            upd_is_2m_i;
    logic            upd_is_1g_i;
    mmu_pkg::perm_t  upd_perm_i;
    logic            lsu_dtlb_hit_o;
    logic            dtlb_miss_o;
    logic            lsu_valid_o;
    mmu_pkg::paddr_t lsu_paddr_o;
    logic            lsu_ex_valid_o;
    mmu_pkg::cause_t lsu_ex_cause_o;
    mmu_pkg::tval_t  lsu_ex_tval_o;

    // fields of the current vector line
    int              fd;
    int              vec_lines;
    int              vec_index;
    logic [7:0]      op;
    logic            v_en;
    logic            v_sum;
    logic            v_store;
    mmu_pkg::priv_t  v_priv;
    mmu_pkg::vaddr_t v_vaddr;
    mmu_pkg::vpn_t   u_vpn;
    mmu_pkg::ppn_t   u_ppn;
    logic            u_2m;
    logic            u_1g;
    mmu_pkg::perm_t  u_perm;
    logic            e_hit;
    logic            e_miss;
    logic            e_valid;
    logic            e_ex_valid;
    mmu_pkg::paddr_t e_paddr;
    mmu_pkg::cause_t e_cause;
    mmu_pkg::tval_t  e_tval;

    // response due in the cycle after the previous line
    logic            p_req;
    logic            p_valid;
    logic            p_ex_valid;
    mmu_pkg::paddr_t p_paddr;
    mmu_pkg::cause_t p_cause;
    mmu_pkg::tval_t  p_tval;

    mmu_top dut0 (.*);

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    task automatic check_value(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        assert (act_val === exp_val) else begin
            $display("Error: %s expected %h actual %h at vector %0d",
                     name, exp_val, act_val, vec_index);
            $display(">>> FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic count_lines();
        int    cfd;
        int    n;
        string s;
        n   = 0;
        cfd = $fopen(VEC_FILE, "r");
        if (cfd == 0) begin
            abort_run("cannot open the vector file");
        end
        while ($fgets(s, cfd) > 0) begin
            n++;
        end
        $fclose(cfd);
        // the watchdog sees the whole count at once
        vec_lines = n;
    endtask

    // refill fields are don't care while upd_valid_i is low
    task automatic drive_idle();
        lsu_req_i   <= 1'b0;
        upd_valid_i <= 1'b0;
        flush_i     <= 1'b0;
        upd_vpn_i   <= mmu_pkg::vpn_t'($urandom());
        upd_ppn_i   <= mmu_pkg::ppn_t'({$urandom(), $urandom()});
        upd_is_2m_i <= 1'($urandom());
        upd_is_1g_i <= 1'($urandom());
        upd_perm_i  <= mmu_pkg::perm_t'($urandom());
    endtask

    task automatic drive_record();
        if (op == "I") begin
            drive_idle();
        end else begin
            lsu_req_i   <= (op == "R");
            upd_valid_i <= (op == "U");
            flush_i     <= (op == "F");
        end
        if (op == "U") begin
            upd_vpn_i   <= u_vpn;
            upd_ppn_i   <= u_ppn;
            upd_is_2m_i <= u_2m;
            upd_is_1g_i <= u_1g;
            upd_perm_i  <= u_perm;
        end else if (op == "R") begin
            en_translation_i <= v_en;
            priv_lvl_i       <= v_priv;
            sum_i            <= v_sum;
            lsu_is_store_i   <= v_store;
            lsu_vaddr_i      <= v_vaddr;
        end
    endtask

    task automatic read_record(output bit at_end);
        int         c;
        int         n;
        int         want;
        bit         found;
        logic [7:0] ch;
        string      rest;
        at_end = 1'b0;
        found  = 1'b0;
        while (!found && !at_end) begin
            c = $fgetc(fd);
            ch = 8'(c);
            if (c == -1) begin
                at_end = 1'b1;
            end else if (ch == "#") begin
                n = $fgets(rest, fd);
            end else if (ch == "I" || ch == "U" || ch == "R" || ch == "F") begin
                op    = ch;
                found = 1'b1;
            end else if (ch != " " && ch != "\t" && ch != "\n" && ch != "\r") begin
                abort_run("unknown opcode in the vector file");
            end
        end
        if (found) begin
            want = 0;
            n    = 0;
            if (op == "U") begin
                want = 5;
                n = $fscanf(fd, " %h %h %h %h %h", u_vpn, u_ppn, u_2m, u_1g, u_perm);
            end else if (op == "R") begin
                want = 12;
                n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h",
                            v_en, v_priv, v_sum, v_store, v_vaddr, e_hit, e_miss,
                            e_valid, e_paddr, e_ex_valid, e_cause, e_tval);
            end
            if (n != want) begin
                abort_run("malformed line in the vector file");
            end
        end
    endtask

    // only a request line expects a response one cycle later
    task automatic check_response();
        check_value("lsu_valid_o", 64'(p_req && p_valid), 64'(lsu_valid_o));
        if (p_req) begin
            if (p_valid) begin
                check_value("lsu_paddr_o", 64'(p_paddr), 64'(lsu_paddr_o));
            end
            check_value("lsu_ex_valid_o", 64'(p_ex_valid), 64'(lsu_ex_valid_o));
            if (p_ex_valid) begin
                check_value("lsu_ex_cause_o", 64'(p_cause), 64'(lsu_ex_cause_o));
                check_value("lsu_ex_tval_o", p_tval, lsu_ex_tval_o);
            end
        end
    endtask

    // ----------------------------------------
    // clock, watchdog and main sequence
    // ----------------------------------------

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    initial begin : watchdog
        wait (vec_lines > 0);
        #((vec_lines + 10) * CLK_PERIOD * 2);
        abort_run("watchdog timeout, the vector run did not finish");
    end

    initial begin : stimulus
        bit at_end;
        void'($urandom(SEED));
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        en_translation_i = 1'b0;
        priv_lvl_i       = '0;
        sum_i            = 1'b0;
        lsu_req_i        = 1'b0;
        lsu_vaddr_i      = '0;
        lsu_is_store_i   = 1'b0;
        upd_valid_i      = 1'b0;
        upd_vpn_i        = '0;
        upd_ppn_i        = '0;
        upd_is_2m_i      = 1'b0;
        upd_is_1g_i      = 1'b0;
        upd_perm_i       = '0;
        vec_index        = 0;
        p_req            = 1'b0;
        count_lines();
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the vector file");
        end

        // two cycles of reset with quiet outputs
        @(posedge clk_i);
        @(negedge clk_i);
        check_value("lsu_valid_o", 64'(0), 64'(lsu_valid_o));
        check_value("lsu_ex_valid_o", 64'(0), 64'(lsu_ex_valid_o));
        check_value("dtlb_miss_o", 64'(0), 64'(dtlb_miss_o));
        @(posedge clk_i);
        rst_ni <= 1'b1;

        at_end = 1'b0;
        while (!at_end) begin
            @(posedge clk_i);
            read_record(at_end);
            if (at_end) begin
                drive_idle();
            end else begin
                vec_index++;
                drive_record();
            end
            @(negedge clk_i);
            check_response();
            if (!at_end) begin
                if (op == "R") begin
                    check_value("lsu_dtlb_hit_o", 64'(e_hit), 64'(lsu_dtlb_hit_o));
                    check_value("dtlb_miss_o", 64'(e_miss), 64'(dtlb_miss_o));
                end
                p_req      = (op == "R");
                p_valid    = e_valid;
                p_paddr    = e_paddr;
                p_ex_valid = e_ex_valid;
                p_cause    = e_cause;
                p_tval     = e_tval;
            end
        end
        $fclose(fd);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* mmu_top.sv */
// Sv39 data MMU top level

`timescale 1ns/1ps

`include "mmu_params.svh"

module mmu_top (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    // control levels
    input  logic            en_translation_i,
    input  mmu_pkg::priv_t  priv_lvl_i,
    input  logic            sum_i,
    // request
    input  logic            lsu_req_i,
    input  mmu_pkg::vaddr_t lsu_vaddr_i,
    input  logic            lsu_is_store_i,
    // TLB refill
    input  logic            upd_valid_i,
    input  mmu_pkg::vpn_t   upd_vpn_i,
    input  mmu_pkg::ppn_t   upd_ppn_i,
    input  logic            upd_is_2m_i,
    input  logic            upd_is_1g_i,
    input  mmu_pkg::perm_t  upd_perm_i,
    // cycle 0
    output logic            lsu_dtlb_hit_o,
    output logic            dtlb_miss_o,
    // cycle 1
    output logic            lsu_valid_o,
    output mmu_pkg::paddr_t lsu_paddr_o,
    output logic            lsu_ex_valid_o,
    output mmu_pkg::cause_t lsu_ex_cause_o,
    output mmu_pkg::tval_t  lsu_ex_tval_o
);

    logic           lu_access;
    logic           lu_hit;
    mmu_pkg::ppn_t  lu_ppn;
    mmu_pkg::perm_t lu_perm;
    logic           lu_is_2m;
    logic           lu_is_1g;

    // only translated requests look up the TLB
    assign lu_access = lsu_req_i & en_translation_i;

    // untranslated requests always hit
    assign lsu_dtlb_hit_o = en_translation_i ? lu_hit : 1'b1;

    // one pulse per translated miss, for the performance counter
    assign dtlb_miss_o = lu_access & ~lu_hit;

    dtlb #(
        .TLB_ENTRIES ( `MMU_TLB_ENTRIES )
    ) u_dtlb (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .flush_i     ( flush_i     ),
        .upd_valid_i ( upd_valid_i ),
        .upd_vpn_i   ( upd_vpn_i   ),
        .upd_ppn_i   ( upd_ppn_i   ),
        .upd_is_2m_i ( upd_is_2m_i ),
        .upd_is_1g_i ( upd_is_1g_i ),
        .upd_perm_i  ( upd_perm_i  ),
        .lu_access_i ( lu_access   ),
        .lu_vaddr_i  ( lsu_vaddr_i ),
        .lu_hit_o    ( lu_hit      ),
        .lu_ppn_o    ( lu_ppn      ),
        .lu_perm_o   ( lu_perm     ),
        .lu_is_2m_o  ( lu_is_2m    ),
        .lu_is_1g_o  ( lu_is_1g    )
    );

    lsu_xlate u_xlate (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .en_translation_i ( en_translation_i ),
        .priv_lvl_i       ( priv_lvl_i       ),
        .sum_i            ( sum_i            ),
        .lsu_req_i        ( lsu_req_i        ),
        .lsu_vaddr_i      ( lsu_vaddr_i      ),
        .lsu_is_store_i   ( lsu_is_store_i   ),
        .lu_hit_i         ( lu_hit           ),
        .lu_ppn_i         ( lu_ppn           ),
        .lu_perm_i        ( lu_perm          ),
        .lu_is_2m_i       ( lu_is_2m         ),
        .lu_is_1g_i       ( lu_is_1g         ),
        .lsu_valid_o      ( lsu_valid_o      ),
        .lsu_paddr_o      ( lsu_paddr_o      ),
        .lsu_ex_valid_o   ( lsu_ex_valid_o   ),
        .lsu_ex_cause_o   ( lsu_ex_cause_o   ),
        .lsu_ex_tval_o    ( lsu_ex_tval_o    )
    );

endmodule

/* mmu_vectors.txt */
# I idle, F flush, U vpn ppn is_2m is_1g perm, all fields hex
# R en priv sum is_store vaddr, then hit miss valid paddr ex_valid cause tval
I
R 0 1 0 0 0012345678 1 0 1 00000012345678 0 00 0000000000000000
R 0 0 0 1 4000001abc 1 0 1 00004000001abc 0 00 0000000000000000
I
U 0000123 00000abcde0 0 0 b
R 1 1 0 0 0000123456 1 0 1 00000abcde0456 0 00 0000000000000000
R 1 1 0 1 0000123ff8 1 0 1 00000abcde0ff8 0 00 0000000000000000
I
U 0040200 00000a001ff 1 0 b
U 0080000 00000c3ffff 0 1 b
R 1 1 0 0 00403ab7c4 1 0 1 00000a001ab7c4 0 00 0000000000000000
R 1 1 0 1 0040202010 1 0 1 00000a00002010 0 00 0000000000000000
R 1 1 0 0 00aaaaa321 1 0 1 00000c2aaaa321 0 00 0000000000000000
R 1 1 0 0 008003f00c 1 0 1 00000c0003f00c 0 00 0000000000000000
I
U 4000200 00000055500 0 0 3
U 0000300 00000066600 0 0 f
R 1 1 0 1 4000200abc 1 0 1 00000055500abc 1 0f ffffffc000200abc
R 1 1 0 0 4000200abc 1 0 1 00000055500abc 0 00 0000000000000000
R 1 1 0 0 0000300010 1 0 1 00000066600010 1 0d 0000000000300010
R 1 1 1 0 0000300010 1 0 1 00000066600010 0 00 0000000000000000
R 1 0 0 0 4000200004 1 0 1 00000055500004 1 0d ffffffc000200004
R 1 0 0 0 0000300020 1 0 1 00000066600020 0 00 0000000000000000
I
R 1 1 0 0 0000400008 0 1 0 00000000000000 0 00 0000000000000000
U 0000400 00000077700 0 0 b
R 1 1 0 0 0000400008 1 0 1 00000077700008 0 00 0000000000000000
R 1 1 0 0 00403ab7c4 0 1 0 00000000000000 0 00 0000000000000000
F
R 1 1 0 0 0000400008 0 1 0 00000000000000 0 00 0000000000000000
R 1 1 0 0 00aaaaa321 0 1 0 00000000000000 0 00 0000000000000000
I
U 0000501 00000bbb501 0 0 b
U 0000502 00000bbb502 0 0 b
U 0000503 00000bbb503 0 0 b
U 0000504 00000bbb504 0 0 b
U 0000505 00000bbb505 0 0 b
R 1 1 0 0 0000501000 0 1 0 00000000000000 0 00 0000000000000000
R 1 1 0 0 0000502000 1 0 1 00000bbb502000 0 00 0000000000000000
R 1 1 0 0 0000503000 1 0 1 00000bbb503000 0 00 0000000000000000
R 1 1 0 0 0000504000 1 0 1 00000bbb504000 0 00 0000000000000000
R 1 1 0 0 0000505000 1 0 1 00000bbb505000 0 00 0000000000000000
R 0 1 0 0 0000501000 1 0 1 00000000501000 0 00 0000000000000000
I

/* run.sh */
#!/bin/sh
# build and run the Sv39 data MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f filelist.f --top-module mmu_tb -o mmu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/mmu_sim > sim.log 2>&1
sim_status=$?

if grep -q ">>> FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status, see sim.log"
    exit 1
fi

echo "simulation passed"
exit 0
